//--- colorPalette.sv
`timescale 1ns/1ps

module colorPalette (
   input  logic                                IsBackground,
   input  logic [videoPkg::PaletteIdxWidth-1:0] PaletteIdx,
   output logic [videoPkg::ColorWidth-1:0]      VGA_R,
   output logic [videoPkg::ColorWidth-1:0]      VGA_G,
   output logic [videoPkg::ColorWidth-1:0]      VGA_B
);

   import videoPkg::*;

   rgbT entry;
   logic [ColorWidth-1:0] red;
   logic [ColorWidth-1:0] green;
   logic [ColorWidth-1:0] blue;

   assign entry = PaletteTable[PaletteIdx];

   always_comb begin
      if (IsBackground) begin
         // Background is plain white
         red   = '1;
         green = '1;
         blue  = '1;
      end else begin
         red   = entry.red;
         green = entry.green;
         blue  = entry.blue;
      end
   end

   assign VGA_R = red;
   assign VGA_G = green;
   assign VGA_B = blue;

endmodule

//--- layerMerge.sv
`timescale 1ns/1ps

module layerMerge #(
   parameter int NumSprites = 4
) (
   input  logic                                           Clk,
   input  logic                                           rst,
   input  logic [NumSprites-1:0]                          Hit,
   input  logic [NumSprites*videoPkg::PaletteIdxWidth-1:0] HitColor,
   input  logic                                           HSyncRaw,
   input  logic                                           VSyncRaw,
   input  logic                                           BlankRaw,
   output logic [videoPkg::PaletteIdxWidth-1:0]            PaletteIdx,
   output logic                                           IsBackground,
   output logic                                           VGA_HS,
   output logic                                           VGA_VS
);

   import videoPkg::*;

   logic                       hSyncD1;
   logic                       vSyncD1;
   logic                       blankD1;
   logic [PaletteIdxWidth-1:0] winIdx;
   logic                       anyHit;

   // Walk downwards so the lowest enabled layer is assigned last and wins
   always_comb begin
      winIdx = BlackIdx;
      anyHit = 1'b0;
      for (int i = NumSprites - 1; i >= 0; i--) begin
         if (Hit[i]) begin
            winIdx = HitColor[i*PaletteIdxWidth +: PaletteIdxWidth];
            anyHit = 1'b1;
         end
      end
   end

   // Line up sync and blank with the layer stage
   always_ff @(posedge Clk) begin
      if (rst) begin
         hSyncD1 <= 1'b1;
         vSyncD1 <= 1'b1;
         blankD1 <= 1'b1;
      end else begin
         hSyncD1 <= HSyncRaw;
         vSyncD1 <= VSyncRaw;
         blankD1 <= BlankRaw;
      end
   end

   always_ff @(posedge Clk) begin
      if (rst) begin
         PaletteIdx   <= BlackIdx;
         IsBackground <= 1'b0;
         VGA_HS       <= 1'b1;
         VGA_VS       <= 1'b1;
      end else begin
         VGA_HS <= hSyncD1;
         VGA_VS <= vSyncD1;
         if (blankD1) begin
            PaletteIdx   <= BlackIdx;    // Black in porches and sync
            IsBackground <= 1'b0;
         end else begin
            PaletteIdx   <= winIdx;
            IsBackground <= ~anyHit;
         end
      end
   end

endmodule

//--- spriteLayer.sv
`timescale 1ns/1ps

module spriteLayer #(
   parameter int LayerIndex = 0,
   parameter int SpriteSize = videoPkg::DefaultSpriteSize,
   parameter int SelWidth   = 2
) (
   input  logic                                Clk,
   input  logic                                rst,
   input  logic [videoPkg::CoordWidth-1:0]      DrawX,
   input  logic [videoPkg::CoordWidth-1:0]      DrawY,
   input  logic                                SpriteWe,
   input  logic [SelWidth-1:0]                 SpriteSel,
   input  logic [videoPkg::CoordWidth-1:0]      SpriteX,
   input  logic [videoPkg::CoordWidth-1:0]      SpriteY,
   input  logic [videoPkg::PaletteIdxWidth-1:0] SpriteColor,
   input  logic                                SpriteEnable,
   output logic                                Hit,
   output logic [videoPkg::PaletteIdxWidth-1:0] HitColor
);

   import videoPkg::*;

   logic [CoordWidth-1:0]      posX;
   logic [CoordWidth-1:0]      posY;
   logic [PaletteIdxWidth-1:0] colorReg;
   logic                       enableReg;
   logic [CoordWidth:0]        lastX;    // One extra bit so the far edge never wraps
   logic [CoordWidth:0]        lastY;
   logic                       inX;
   logic                       inY;
   logic                       selected;

   assign selected = SpriteWe && (SpriteSel == SelWidth'(LayerIndex));

   always_ff @(posedge Clk) begin
      if (rst) begin
         enableReg <= 1'b0;
      end else if (selected) begin
         enableReg <= SpriteEnable;
      end
   end

   always_ff @(posedge Clk) begin
      if (selected) begin
         posX     <= SpriteX;
         posY     <= SpriteY;
         colorReg <= SpriteColor;
      end
   end

   assign lastX = {1'b0, posX} + (CoordWidth + 1)'(SpriteSize - 1);
   assign lastY = {1'b0, posY} + (CoordWidth + 1)'(SpriteSize - 1);
   assign inX   = (DrawX >= posX) && ({1'b0, DrawX} <= lastX);
   assign inY   = (DrawY >= posY) && ({1'b0, DrawY} <= lastY);

   always_ff @(posedge Clk) begin
      if (rst) begin
         Hit <= 1'b0;
      end else begin
         Hit <= enableReg && inX && inY;
      end
   end

   // Colour travels with Hit so a mid-line write stays consistent
   always_ff @(posedge Clk) begin
      HitColor <= colorReg;
   end

endmodule

//--- spriteRenderer.f
videoPkg.sv
vgaTiming.sv
spriteLayer.sv
layerMerge.sv
colorPalette.sv
spriteRenderer.sv
spriteRenderer_assert.sv
spriteRenderer_tb.sv

//--- spriteRenderer.sv
`timescale 1ns/1ps

module spriteRenderer #(
   parameter int NumSprites  = 4,
   parameter int SpriteSize  = videoPkg::DefaultSpriteSize,
   parameter int HActive     = 640,
   parameter int HFrontPorch = 16,
   parameter int HSyncLen    = 96,
   parameter int HBackPorch  = 48,
   parameter int VActive     = 480,
   parameter int VFrontPorch = 10,
   parameter int VSyncLen    = 2,
   parameter int VBackPorch  = 33,
   localparam int SelWidth   = (NumSprites > 1) ? $clog2(NumSprites) : 1
) (
   input  logic                                Clk,
   input  logic                                rst,
   input  logic                                SpriteWe,
   input  logic [SelWidth-1:0]                 SpriteSel,
   input  logic [videoPkg::CoordWidth-1:0]      SpriteX,
   input  logic [videoPkg::CoordWidth-1:0]      SpriteY,
   input  logic [videoPkg::PaletteIdxWidth-1:0] SpriteColor,
   input  logic                                SpriteEnable,
   output logic [videoPkg::ColorWidth-1:0]      VGA_R,
   output logic [videoPkg::ColorWidth-1:0]      VGA_G,
   output logic [videoPkg::ColorWidth-1:0]      VGA_B,
   output logic                                VGA_HS,
   output logic                                VGA_VS,
   output logic                                FrameStart
);

   import videoPkg::*;

   logic [CoordWidth-1:0]                 drawX;
   logic [CoordWidth-1:0]                 drawY;
   logic                                  hSyncRaw;
   logic                                  vSyncRaw;
   logic                                  blankRaw;
   logic [NumSprites-1:0]                 hit;
   logic [NumSprites*PaletteIdxWidth-1:0] hitColor;
   logic [PaletteIdxWidth-1:0]            paletteIdx;
   logic                                  isBackground;

   vgaTiming #(
      .HActive(HActive),
      .HFrontPorch(HFrontPorch),
      .HSyncLen(HSyncLen),
      .HBackPorch(HBackPorch),
      .VActive(VActive),
      .VFrontPorch(VFrontPorch),
      .VSyncLen(VSyncLen),
      .VBackPorch(VBackPorch)
   ) u_vgaTiming (
      .Clk(Clk),
      .rst(rst),
      .DrawX(drawX),
      .DrawY(drawY),
      .HSyncRaw(hSyncRaw),
      .VSyncRaw(vSyncRaw),
      .BlankRaw(blankRaw),
      .FrameStart(FrameStart)
   );

   // All layers see the same write bus and pick their own strobe
   for (genvar i = 0; i < NumSprites; i++) begin : gLayer
      spriteLayer #(
         .LayerIndex(i),
         .SpriteSize(SpriteSize),
         .SelWidth(SelWidth)
      ) u_spriteLayer (
         .Clk(Clk),
         .rst(rst),
         .DrawX(drawX),
         .DrawY(drawY),
         .SpriteWe(SpriteWe),
         .SpriteSel(SpriteSel),
         .SpriteX(SpriteX),
         .SpriteY(SpriteY),
         .SpriteColor(SpriteColor),
         .SpriteEnable(SpriteEnable),
         .Hit(hit[i]),
         .HitColor(hitColor[i*PaletteIdxWidth +: PaletteIdxWidth])
      );
   end

   layerMerge #(
      .NumSprites(NumSprites)
   ) u_layerMerge (
      .Clk(Clk),
      .rst(rst),
      .Hit(hit),
      .HitColor(hitColor),
      .HSyncRaw(hSyncRaw),
      .VSyncRaw(vSyncRaw),
      .BlankRaw(blankRaw),
      .PaletteIdx(paletteIdx),
      .IsBackground(isBackground),
      .VGA_HS(VGA_HS),
      .VGA_VS(VGA_VS)
   );

   colorPalette u_colorPalette (
      .IsBackground(isBackground),
      .PaletteIdx(paletteIdx),
      .VGA_R(VGA_R),
      .VGA_G(VGA_G),
      .VGA_B(VGA_B)
   );

endmodule

//--- spriteRenderer_assert.sv
`timescale 1ns/1ps

module mergeChecks (
   input logic                                Clk,
   input logic                                rst,
   input logic                                BlankRaw,
   input logic [videoPkg::PaletteIdxWidth-1:0] PaletteIdx,
   input logic                                IsBackground,
   input logic                                VGA_HS,
   input logic                                VGA_VS
);

   import videoPkg::*;

   int failCount = 0;

   // Raw blank reaches the output two cycles later and never counts as background
   assert property (@(posedge Clk) disable iff (rst) BlankRaw |-> ##2 !IsBackground)
      else begin
         failCount++;
         $error("IsBackground high during blanking");
      end

   assert property (@(posedge Clk) disable iff (rst)
                    BlankRaw |-> ##2 (PaletteIdx == BlackIdx))
      else begin
         failCount++;
         $error("PaletteIdx not black during blanking");
      end

   assert property (@(posedge Clk) rst |=> (VGA_HS && VGA_VS))
      else begin
         failCount++;
         $error("Sync outputs not idle after reset");
      end

endmodule

bind layerMerge mergeChecks u_mergeChecks (
   .Clk(Clk),
   .rst(rst),
   .BlankRaw(BlankRaw),
   .PaletteIdx(PaletteIdx),
   .IsBackground(IsBackground),
   .VGA_HS(VGA_HS),
   .VGA_VS(VGA_VS)
);

//--- spriteRenderer_tb.sv
`timescale 1ns/1ps

module spriteRenderer_tb;

   import videoPkg::*;

   localparam int NumSprites  = 4;
   localparam int SpriteSize  = 4;
   localparam int HActive     = 24;
   localparam int HFrontPorch = 2;
   localparam int HSyncLen    = 3;
   localparam int HBackPorch  = 3;
   localparam int VActive     = 12;
   localparam int VFrontPorch = 1;
   localparam int VSyncLen    = 2;
   localparam int VBackPorch  = 2;
   localparam int HTotal      = HActive + HFrontPorch + HSyncLen + HBackPorch;
   localparam int VTotal      = VActive + VFrontPorch + VSyncLen + VBackPorch;
   localparam int FrameCycles = HTotal * VTotal;
   localparam int SlotWidth   = HActive / NumSprites;    // Column band per layer

   logic Clk;
   logic rst;
   logic SpriteWe;
   logic [1:0] SpriteSel;
   logic [CoordWidth-1:0] SpriteX;
   logic [CoordWidth-1:0] SpriteY;
   logic [PaletteIdxWidth-1:0] SpriteColor;
   logic SpriteEnable;
   logic [ColorWidth-1:0] VGA_R;
   logic [ColorWidth-1:0] VGA_G;
   logic [ColorWidth-1:0] VGA_B;
   logic VGA_HS;
   logic VGA_VS;
   logic FrameStart;

   // Model state
   int mx;
   int my;
   int sprX [NumSprites];
   int sprY [NumSprites];
   int sprC [NumSprites];
   logic sprEn [NumSprites];
   logic [25:0] exp0;    // {hs, vs, rgb} of the pixel one stage in
   logic [25:0] exp1;
   logic checkOn;
   int perm [32];

   spriteRenderer #(
      .NumSprites(NumSprites), .SpriteSize(SpriteSize),
      .HActive(HActive), .HFrontPorch(HFrontPorch), .HSyncLen(HSyncLen),
      .HBackPorch(HBackPorch), .VActive(VActive), .VFrontPorch(VFrontPorch),
      .VSyncLen(VSyncLen), .VBackPorch(VBackPorch)
   ) u_spriteRenderer (
      .Clk(Clk), .rst(rst), .SpriteWe(SpriteWe), .SpriteSel(SpriteSel),
      .SpriteX(SpriteX), .SpriteY(SpriteY), .SpriteColor(SpriteColor),
      .SpriteEnable(SpriteEnable), .VGA_R(VGA_R), .VGA_G(VGA_G), .VGA_B(VGA_B),
      .VGA_HS(VGA_HS), .VGA_VS(VGA_VS), .FrameStart(FrameStart)
   );

   initial begin
      Clk = 1'b0;
      forever #4 Clk = ~Clk;
   end

   function automatic logic [25:0] expectedPixel(input int x, input int y);
      logic hs;
      logic vs;
      logic [23:0] rgb;
      int win;
      hs = !((x >= HActive + HFrontPorch) && (x < HActive + HFrontPorch + HSyncLen));
      vs = !((y >= VActive + VFrontPorch) && (y < VActive + VFrontPorch + VSyncLen));
      win = -1;
      for (int i = 0; i < NumSprites; i++) begin
         if (win < 0 && sprEn[i] && x >= sprX[i] && x < sprX[i] + SpriteSize &&
             y >= sprY[i] && y < sprY[i] + SpriteSize) begin
            win = i;
         end
      end
      if (x >= HActive || y >= VActive) rgb = PaletteTable[BlackIdx];
      else if (win < 0) rgb = 24'hffffff;    // Background
      else rgb = PaletteTable[sprC[win]];
      return {hs, vs, rgb};
   endfunction

   // Model steps with the DUT counters; writes land after the current pixel
   always @(posedge Clk) begin
      checkOn = !rst;
      if (rst) begin
         mx = 0;
         my = 0;
         exp0 = {2'b11, 24'(PaletteTable[BlackIdx])};
         exp1 = exp0;
         for (int i = 0; i < NumSprites; i++) begin
            sprEn[i] = 1'b0;
            sprX[i] = 0;
            sprY[i] = 0;
            sprC[i] = 0;
         end
      end else begin
         exp1 = exp0;
         exp0 = expectedPixel(mx, my);
         if (SpriteWe) begin
            sprX[SpriteSel] = SpriteX;
            sprY[SpriteSel] = SpriteY;
            sprC[SpriteSel] = SpriteColor;
            sprEn[SpriteSel] = SpriteEnable;
         end
         mx = mx + 1;
         if (mx == HTotal) begin
            mx = 0;
            my = (my == VTotal - 1) ? 0 : my + 1;
         end
      end
   end

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s got %h expected %h", $time, name, actual, expected);
         $display("Finished with errors");
         $fatal(1, "Output mismatch");
      end
   endtask

   always @(negedge Clk) begin
      if (u_spriteRenderer.u_layerMerge.u_mergeChecks.failCount != 0) begin
         $display("An assertion on the merge stage failed at %0t", $time);
         $display("Finished with errors");
         $fatal(1, "Assertion failure");
      end
      if (checkOn) begin
         checkValue("VGA_RGB", {VGA_R, VGA_G, VGA_B}, exp1[23:0]);
         checkValue("VGA_HS", VGA_HS, exp1[25]);
         checkValue("VGA_VS", VGA_VS, exp1[24]);
         checkValue("FrameStart", FrameStart, (mx == 0 && my == 0));
      end
   end

   task automatic abortRun(input string what);
      $display("Timed out waiting for %s", what);
      $display("Finished with errors");
      $fatal(1, "Timeout");
   endtask

   task automatic waitFrameStart();
      for (int i = 0; i < 2 * FrameCycles; i++) begin
         @(negedge Clk);
         if (FrameStart) return;
      end
      abortRun("the frame start pulse");
   endtask

   task automatic waitVBlank();
      for (int i = 0; i < 2 * FrameCycles; i++) begin
         if (my >= VActive) return;
         @(negedge Clk);
      end
      abortRun("the vertical blank");
   endtask

   // One whole active area goes by, then back into vertical blank
   task automatic renderFrame();
      waitFrameStart();
      waitVBlank();
   endtask

   task automatic loadSprite(input int layer, input int x, input int y, input int color,
                             input logic en);
      SpriteWe = 1'b1;
      SpriteSel = layer[1:0];
      SpriteX = x[CoordWidth-1:0];
      SpriteY = y[CoordWidth-1:0];
      SpriteColor = color[PaletteIdxWidth-1:0];
      SpriteEnable = en;
      @(negedge Clk);
      SpriteWe = 1'b0;
   endtask

   initial begin
      int j;
      int tmp;
      int writes;
      void'($urandom(32'hcf88));
      rst = 1'b1;
      SpriteWe = 1'b0;
      SpriteSel = '0;
      SpriteX = '0;
      SpriteY = '0;
      SpriteColor = '0;
      SpriteEnable = 1'b0;
      repeat (8) @(negedge Clk);
      rst = 1'b0;
      waitVBlank();                          // Frame with every layer off
      loadSprite(0, 5, 3, 9, 1'b1);
      loadSprite(1, 22, 10, 4, 1'b1);        // Clipped right and bottom
      renderFrame();
      loadSprite(0, 8, 4, 12, 1'b1);
      loadSprite(1, 10, 6, 5, 1'b1);
      loadSprite(2, 9, 5, 2, 1'b1);          // White but not background
      renderFrame();
      loadSprite(0, 8, 4, 12, 1'b0);
      renderFrame();
      loadSprite(3, 0, 0, 0, 1'b1);
      loadSprite(2, 18, 7, 25, 1'b1);
      renderFrame();
      // Every palette index once, in a shuffled order
      for (int i = 0; i < 32; i++) perm[i] = i;
      for (int i = 31; i > 0; i--) begin
         j = $urandom_range(i, 0);
         tmp = perm[i];
         perm[i] = perm[j];
         perm[j] = tmp;
      end
      // Each layer stays in its own column band so every index is visible
      for (int f = 0; f < 8; f++) begin
         for (int k = 0; k < NumSprites; k++) begin
            loadSprite(k, k * SlotWidth + $urandom_range(SlotWidth - SpriteSize, 0),
                       $urandom_range(VActive - 1, 0), perm[f * NumSprites + k], 1'b1);
         end
         renderFrame();
      end
      for (int f = 0; f < 6; f++) begin
         writes = $urandom_range(3, 1);
         for (int k = 0; k < writes; k++) begin
            loadSprite($urandom_range(NumSprites - 1, 0), $urandom_range(HActive - 1, 0),
                       $urandom_range(VActive - 1, 0), $urandom_range(31, 0),
                       1'($urandom_range(1, 0)));
         end
         renderFrame();
      end
      if (u_spriteRenderer.u_layerMerge.u_mergeChecks.failCount == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- vgaTiming.sv
`timescale 1ns/1ps

module vgaTiming #(
   parameter int HActive     = 640,
   parameter int HFrontPorch = 16,
   parameter int HSyncLen    = 96,
   parameter int HBackPorch  = 48,
   parameter int VActive     = 480,
   parameter int VFrontPorch = 10,
   parameter int VSyncLen    = 2,
   parameter int VBackPorch  = 33
) (
   input  logic                           Clk,
   input  logic                           rst,
   output logic [videoPkg::CoordWidth-1:0] DrawX,
   output logic [videoPkg::CoordWidth-1:0] DrawY,
   output logic                           HSyncRaw,
   output logic                           VSyncRaw,
   output logic                           BlankRaw,
   output logic                           FrameStart
);

   import videoPkg::*;

   localparam int HSyncStart = HActive + HFrontPorch;
   localparam int HSyncEnd   = HSyncStart + HSyncLen;
   localparam int HTotal     = HSyncEnd + HBackPorch;
   localparam int VSyncStart = VActive + VFrontPorch;
   localparam int VSyncEnd   = VSyncStart + VSyncLen;
   localparam int VTotal     = VSyncEnd + VBackPorch;

   logic [CoordWidth-1:0] hCount;
   logic [CoordWidth-1:0] vCount;
   logic lineEnd;
   logic frameEnd;

   assign lineEnd  = (hCount == CoordWidth'(HTotal - 1));
   assign frameEnd = (vCount == CoordWidth'(VTotal - 1));

   always_ff @(posedge Clk) begin
      if (rst) begin
         hCount <= '0;
         vCount <= '0;
      end else if (lineEnd) begin
         hCount <= '0;
         if (frameEnd) begin
            vCount <= '0;
         end else begin
            vCount <= vCount + 1'b1;
         end
      end else begin
         hCount <= hCount + 1'b1;
      end
   end

   assign DrawX = hCount;
   assign DrawY = vCount;

   // Syncs are active low inside their window
   assign HSyncRaw = ~((hCount >= CoordWidth'(HSyncStart)) && (hCount < CoordWidth'(HSyncEnd)));
   assign VSyncRaw = ~((vCount >= CoordWidth'(VSyncStart)) && (vCount < CoordWidth'(VSyncEnd)));

   assign BlankRaw   = (hCount >= CoordWidth'(HActive)) || (vCount >= CoordWidth'(VActive));
   assign FrameStart = (hCount == '0) && (vCount == '0);

endmodule

//--- videoPkg.sv
package videoPkg;

   localparam int CoordWidth = 10;
   localparam int PaletteIdxWidth = 5;
   localparam int ColorWidth = 8;
   localparam int DefaultSpriteSize = 16;

   localparam logic [PaletteIdxWidth-1:0] BlackIdx = 5'd1;

   typedef struct packed {
      logic [ColorWidth-1:0] red;
      logic [ColorWidth-1:0] green;
      logic [ColorWidth-1:0] blue;
   } rgbT;

   // Game colours live in 1..18, everything else reads as black
   localparam rgbT PaletteTable [32] = '{
      24'h000000, // Unused
      24'h000000, // Black
      24'hffffff, // White
      24'hd63100,
      24'hff2910,
      24'hff5a00,
      24'hc58c21,
      24'hc5a519,
      24'hefd629,
      24'h42ce5a,
      24'h314a7b,
      24'h3a5ad6,
      24'h425aff,
      24'h5a528c,
      24'h5a2973,
      24'h4a0084,
      24'hce52ce,
      24'hff7bff,
      24'hef3a73,
      24'h000000, 24'h000000, 24'h000000, 24'h000000, 24'h000000,
      24'h000000, 24'h000000, 24'h000000, 24'h000000, 24'h000000,
      24'h000000, 24'h000000, 24'h000000
   };

endpackage
